/* build.f */
+incdir+tests
common/fifoCfgPkg.sv
common/fifoTypesPkg.sv
rtl/fifoStorage.sv
rtl/fifoOccupancy.sv
rtl/fifoHeadBuffer.sv
tests/tbFifoHeadBuffer.sv

/* common/fifoCfgPkg.sv */
`default_nettype none

// default sizing of the head-register FIFO
// the top level takes these as parameter defaults and the testbench sizes
// its reference model from the same values
package fifoCfgPkg;

   // width of one data word
   parameter int DefaultDataWidth = 32;

   // memory entries, capacity is one more because of the head register
   // 6 is not a power of two, so the pointer wrap is exercised
   parameter int DefaultDepth = 6;

   // almostEmpty while occupancy <= this level
   parameter int DefaultAeThreshold = 2;

   // almostFull while occupancy >= this level
   parameter int DefaultAfThreshold = 5;

endpackage : fifoCfgPkg

`default_nettype wire

/* common/fifoTypesPkg.sv */
`default_nettype none

// signal bundles passed between the FIFO blocks and out of the top level
package fifoTypesPkg;

   // registered status flags, all taken from the occupancy after the edge
   typedef struct packed {
      logic empty;
      logic almostEmpty;
      logic full;
      logic almostFull;
   } fifoStatus_t;

   // per-cycle decisions from the occupancy block to the storage block
   typedef struct packed {
      // write taken, memory is written at the write pointer
      logic wrAccept;
      // read taken, the head word leaves the FIFO
      logic rdAccept;
      // head loads the incoming word directly
      logic bypass;
      // head loads the memory word at the read pointer
      logic reload;
      // read pointer steps to the next entry
      logic advanceRd;
   } headCtrl_t;

endpackage : fifoTypesPkg

`default_nettype wire

/* rtl/fifoHeadBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

// first-word-fall-through FIFO with a registered head word
// capacity is Depth + 1, dataOut is valid whenever status.empty is low
// requests that would overflow or underflow are dropped
module fifoHeadBuffer #(
   parameter int DataWidth = fifoCfgPkg::DefaultDataWidth,
   parameter int Depth = fifoCfgPkg::DefaultDepth,
   parameter int AeThreshold = fifoCfgPkg::DefaultAeThreshold,
   parameter int AfThreshold = fifoCfgPkg::DefaultAfThreshold
) (
   input wire logic clkin,
   input wire logic reset_n,
   input wire logic syncReset_n,
   input wire logic wrEn,
   input wire logic [DataWidth-1:0] wrData,
   input wire logic rdEn,
   output logic [DataWidth-1:0] dataOut,
   output fifoTypesPkg::fifoStatus_t status
);

   // accept and head decisions for this cycle
   fifoTypesPkg::headCtrl_t headCtrl;

   // counter, accept gating and flags
   fifoOccupancy #(
      .Depth(Depth),
      .AeThreshold(AeThreshold),
      .AfThreshold(AfThreshold)
   ) occ0 (
      .clkin(clkin),
      .reset_n(reset_n),
      .syncReset_n(syncReset_n),
      .wrEn(wrEn),
      .rdEn(rdEn),
      .ctrl(headCtrl),
      .status(status)
   );

   // memory, pointers and head word
   fifoStorage #(
      .DataWidth(DataWidth),
      .Depth(Depth)
   ) stor0 (
      .clkin(clkin),
      .reset_n(reset_n),
      .syncReset_n(syncReset_n),
      .ctrl(headCtrl),
      .wrData(wrData),
      .dataOut(dataOut)
   );

endmodule : fifoHeadBuffer

`default_nettype wire

/* rtl/fifoOccupancy.sv */
`timescale 1ns/1ps
`default_nettype none

// occupancy control of the head-register FIFO
// counts words held (memory plus head), decides which requests are taken
// and tells the storage how to move the head
module fifoOccupancy #(
   parameter int Depth = 6,
   parameter int AeThreshold = 2,
   parameter int AfThreshold = 5
) (
   input wire logic clkin,
   input wire logic reset_n,
   input wire logic syncReset_n,
   input wire logic wrEn,
   input wire logic rdEn,
   output fifoTypesPkg::headCtrl_t ctrl,
   output fifoTypesPkg::fifoStatus_t status
);

   // the head register adds one slot on top of the memory
   localparam int Capacity = Depth + 1;
   // one spare bit, so a count past capacity can be represented
   localparam int CntWidth = $clog2(Capacity) + 1;

   localparam logic [CntWidth-1:0] FullLevel = CntWidth'(Capacity);
   localparam logic [CntWidth-1:0] AeLevel = CntWidth'(AeThreshold);
   localparam logic [CntWidth-1:0] AfLevel = CntWidth'(AfThreshold);

   logic [CntWidth-1:0] occ;
   logic [CntWidth-1:0] occNext;
   logic wrOk;
   logic rdOk;
   logic bypass;

   // accept decisions
   // a write at capacity still goes in when a read frees the head
   always_comb begin
      rdOk = rdEn && (occ != '0);
      wrOk = wrEn && ((occ < FullLevel) || rdOk);
      bypass = wrOk && ((occ == '0) || (rdOk && (occ == CntWidth'(1))));
   end

   // head control, straight from the request and the current count
   always_comb begin
      ctrl.wrAccept = wrOk;
      ctrl.rdAccept = rdOk;
      ctrl.bypass = bypass;
      // memory word moves up unless the new word bypasses it at occupancy one
      ctrl.reload = rdOk && ((occ > CntWidth'(1)) || !wrOk);
      // at occupancy one the memory has nothing left behind the head
      ctrl.advanceRd = (rdOk && (occ > CntWidth'(1))) || bypass;
   end

   // count after this edge
   always_comb begin
      occNext = occ;
      if (wrOk && !rdOk) begin
         occNext = occ + 1'b1;
      end else if (rdOk && !wrOk) begin
         occNext = occ - 1'b1;
      end
   end

   always_ff @(posedge clkin) begin
      if (!reset_n || !syncReset_n) begin
         occ <= '0;
      end else begin
         occ <= occNext;
      end
   end

   // flags registered once from the next count, so they match occ after the edge
   always_ff @(posedge clkin) begin
      if (!reset_n || !syncReset_n) begin
         status.empty <= 1'b1;
         status.almostEmpty <= 1'b1;
         status.full <= 1'b0;
         status.almostFull <= 1'b0;
      end else begin
         status.empty <= (occNext == '0);
         status.almostEmpty <= (occNext <= AeLevel);
         status.full <= (occNext == FullLevel);
         status.almostFull <= (occNext >= AfLevel);
      end
   end

   // count stays within memory plus head
   occInRange: assert property (
      @(posedge clkin) disable iff (!reset_n)
      occ <= FullLevel
   );

   // flags come from one count, so these two exclude each other
   notEmptyAndFull: assert property (
      @(posedge clkin) disable iff (!reset_n)
      !(status.empty && status.full)
   );

   // head has a single source per edge
   oneHeadSource: assert property (
      @(posedge clkin) disable iff (!reset_n)
      !(ctrl.bypass && ctrl.reload)
   );

endmodule : fifoOccupancy

`default_nettype wire

/* rtl/fifoStorage.sv */
`timescale 1ns/1ps
`default_nettype none

// data path of the head-register FIFO
// holds the distributed memory, both pointers and the head word
// every decision comes in on ctrl, nothing here looks at occupancy
module fifoStorage #(
   parameter int DataWidth = 32,
   parameter int Depth = 6
) (
   input wire logic clkin,
   input wire logic reset_n,
   input wire logic syncReset_n,
   input wire fifoTypesPkg::headCtrl_t ctrl,
   input wire logic [DataWidth-1:0] wrData,
   output logic [DataWidth-1:0] dataOut
);

   // a depth of one still needs a one-bit pointer
   localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
   localparam logic [PtrWidth-1:0] LastEntry = PtrWidth'(Depth - 1);

   logic [DataWidth-1:0] mem [Depth];
   logic [PtrWidth-1:0] wrPtr;
   logic [PtrWidth-1:0] rdPtr;
   logic [DataWidth-1:0] headWord;
   logic [DataWidth-1:0] memRdData;

   // wraps at the last entry, so any depth works
   function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
      logic [PtrWidth-1:0] stepped;
      stepped = ptr + 1'b1;
      if (ptr == LastEntry) begin
         stepped = '0;
      end
      return stepped;
   endfunction

   // write pointer steps on every accepted write, bypass included
   always_ff @(posedge clkin) begin
      if (!reset_n || !syncReset_n) begin
         wrPtr <= '0;
      end else if (ctrl.wrAccept) begin
         wrPtr <= nextPtr(wrPtr);
      end
   end

   // read pointer always points one past the word held in the head
   always_ff @(posedge clkin) begin
      if (!reset_n || !syncReset_n) begin
         rdPtr <= '0;
      end else if (ctrl.advanceRd) begin
         rdPtr <= nextPtr(rdPtr);
      end
   end

   // memory is written even on bypass, the read pointer skips that entry
   always_ff @(posedge clkin) begin
      if (ctrl.wrAccept) begin
         mem[wrPtr] <= wrData;
      end
   end

   assign memRdData = mem[rdPtr];

   // head word, which is what the consumer sees
   always_ff @(posedge clkin) begin
      if (!reset_n || !syncReset_n) begin
         headWord <= '0;
      end else if (ctrl.bypass) begin
         headWord <= wrData;
      end else if (ctrl.reload) begin
         // old entry is read when a write to the same slot lands this edge
         headWord <= memRdData;
      end
   end

   assign dataOut = headWord;

   // head refills from memory only when the consumer actually took a word
   reloadNeedsRead: assert property (
      @(posedge clkin) disable iff (!reset_n)
      ctrl.reload |-> ctrl.rdAccept
   );

endmodule : fifoStorage

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile the FIFO testbench with Verilator and run it
# exit status is nonzero when the testbench fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f build.f \
   --top-module tbFifoHeadBuffer \
   -Mdir obj_dir

./obj_dir/VtbFifoHeadBuffer

/* tests/tbFifoChecks.svh */
`ifndef TBFIFOCHECKS_SVH
`define TBFIFOCHECKS_SVH

// compare tasks for the FIFO testbench
// included inside tbFifoHeadBuffer, so DataWidth and abortRun come from there

// one data word against its expected value
task automatic checkData(
   input string name,
   input logic [DataWidth-1:0] expected,
   input logic [DataWidth-1:0] actual
);
   if (actual !== expected) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
      abortRun();
   end
endtask

// all four flags at once, printed field by field
task automatic checkStatus(
   input string name,
   input fifoTypesPkg::fifoStatus_t expected,
   input fifoTypesPkg::fifoStatus_t actual
);
   if (actual !== expected) begin
      $display("ERR t=%0t %s expected e=%b ae=%b f=%b af=%b actual e=%b ae=%b f=%b af=%b",
               $time, name,
               expected.empty, expected.almostEmpty, expected.full, expected.almostFull,
               actual.empty, actual.almostEmpty, actual.full, actual.almostFull);
      abortRun();
   end
endtask

// flags right after either reset
function automatic fifoTypesPkg::fifoStatus_t resetStatus();
   fifoTypesPkg::fifoStatus_t s;
   s.empty = 1'b1;
   s.almostEmpty = 1'b1;
   s.full = 1'b0;
   s.almostFull = 1'b0;
   return s;
endfunction

`endif

/* tests/tbFifoHeadBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

// directed tests of the head-register FIFO against a queue model
module tbFifoHeadBuffer;

   localparam int DataWidth = fifoCfgPkg::DefaultDataWidth;
   localparam int Depth = fifoCfgPkg::DefaultDepth;
   localparam int AeThreshold = fifoCfgPkg::DefaultAeThreshold;
   localparam int AfThreshold = fifoCfgPkg::DefaultAfThreshold;
   // memory entries plus the head word
   localparam int Capacity = Depth + 1;
   localparam int ClkPeriod = 40;

   // cycles each test drives, used to size the watchdog
   localparam int ResetCycles = 4;
   localparam int FillDrainCycles = 4 * Capacity;
   localparam int BypassCycles = 14;
   localparam int RejectCycles = 2 * Capacity + 6;
   localparam int ClearCycles = 12;
   localparam int MarginCycles = 20;
   localparam int TotalCycles = ResetCycles + FillDrainCycles + BypassCycles
                                + RejectCycles + ClearCycles;

   logic clkin;
   logic reset_n;
   logic syncReset_n;
   logic wrEn;
   logic [DataWidth-1:0] wrData;
   logic rdEn;
   logic [DataWidth-1:0] dataOut;
   fifoTypesPkg::fifoStatus_t status;

   // words the FIFO should hold, oldest first
   logic [DataWidth-1:0] model [$];
   int seed = 32'h5ed7;

   fifoHeadBuffer dut0 (
      .clkin(clkin),
      .reset_n(reset_n),
      .syncReset_n(syncReset_n),
      .wrEn(wrEn),
      .wrData(wrData),
      .rdEn(rdEn),
      .dataOut(dataOut),
      .status(status)
   );

   always #(ClkPeriod / 2) clkin = ~clkin;

   task automatic abortRun();
      $display("TB FAILED");
      $fatal(1, "stopping after the first error");
   endtask

   `include "tbFifoChecks.svh"

   function automatic logic [DataWidth-1:0] nextWord();
      return DataWidth'($random(seed));
   endfunction

   // flag rules on the occupancy after the edge
   function automatic fifoTypesPkg::fifoStatus_t expectStatus(input int occ);
      fifoTypesPkg::fifoStatus_t s;
      s.empty = (occ == 0);
      s.almostEmpty = (occ <= AeThreshold);
      s.full = (occ == Capacity);
      s.almostFull = (occ >= AfThreshold);
      return s;
   endfunction

   // one clock of requests, driven at a falling edge and checked at the next
   task automatic applyCycle(
      input logic wr,
      input logic [DataWidth-1:0] data,
      input logic rd
   );
      bit rdTaken;
      bit wrTaken;
      rdTaken = rd && (model.size() > 0);
      // a read frees room for a write at capacity
      wrTaken = wr && ((model.size() < Capacity) || rdTaken);
      wrEn = wr;
      wrData = data;
      rdEn = rd;
      @(posedge clkin);
      @(negedge clkin);
      if (rdTaken) begin
         void'(model.pop_front());
      end
      if (wrTaken) begin
         model.push_back(data);
      end
      wrEn = 1'b0;
      rdEn = 1'b0;
      checkStatus("status", expectStatus(model.size()), status);
      // dataOut only means something while not empty
      if (model.size() > 0) begin
         checkData("dataOut", model[0], dataOut);
      end
   endtask

   task automatic testReset();
      checkStatus("status", resetStatus(), status);
      applyCycle(1'b0, '0, 1'b0);
      checkStatus("status", resetStatus(), status);
   endtask

   // two rounds so both pointers pass the wrap more than once
   task automatic testFillDrain();
      for (int round = 0; round < 2; round++) begin
         for (int i = 0; i < Capacity; i++) begin
            applyCycle(1'b1, nextWord(), 1'b0);
         end
         for (int i = 0; i < Capacity; i++) begin
            applyCycle(1'b0, '0, 1'b1);
         end
      end
   endtask

   task automatic testBypass();
      // empty FIFO, word shows on dataOut one edge later
      applyCycle(1'b1, nextWord(), 1'b0);
      // occupancy one, head swaps in the new word
      repeat (4) applyCycle(1'b1, nextWord(), 1'b1);
      repeat (2) applyCycle(1'b1, nextWord(), 1'b0);
      // mid occupancy, count holds and order is kept
      repeat (4) applyCycle(1'b1, nextWord(), 1'b1);
      repeat (3) applyCycle(1'b0, '0, 1'b1);
   endtask

   task automatic testRejected();
      repeat (Capacity) applyCycle(1'b1, nextWord(), 1'b0);
      // full with no read, write dropped
      applyCycle(1'b1, nextWord(), 1'b0);
      // full with a read, write taken
      applyCycle(1'b1, nextWord(), 1'b1);
      repeat (Capacity) applyCycle(1'b0, '0, 1'b1);
      // empty reads are ignored
      repeat (2) applyCycle(1'b0, '0, 1'b1);
      // pointers still line up afterwards
      applyCycle(1'b1, nextWord(), 1'b0);
      applyCycle(1'b0, '0, 1'b1);
   endtask

   // clear wins over requests in the same cycle
   task automatic syncClear();
      syncReset_n = 1'b0;
      wrEn = 1'b1;
      wrData = nextWord();
      rdEn = 1'b1;
      @(posedge clkin);
      @(negedge clkin);
      model.delete();
      syncReset_n = 1'b1;
      wrEn = 1'b0;
      rdEn = 1'b0;
      checkStatus("status", resetStatus(), status);
   endtask

   task automatic testSyncClear();
      repeat (4) applyCycle(1'b1, nextWord(), 1'b0);
      applyCycle(1'b0, '0, 1'b1);
      syncClear();
      repeat (3) applyCycle(1'b1, nextWord(), 1'b0);
      repeat (3) applyCycle(1'b0, '0, 1'b1);
   endtask

   initial begin
      clkin = 1'b0;
      reset_n = 1'b0;
      syncReset_n = 1'b1;
      wrEn = 1'b0;
      wrData = '0;
      rdEn = 1'b0;
      repeat (2) @(posedge clkin);
      @(negedge clkin);
      reset_n = 1'b1;
      testReset();
      testFillDrain();
      testBypass();
      testRejected();
      testSyncClear();
      $display("TB PASSED");
      $finish;
   end

   // watchdog
   initial begin
      #((TotalCycles + MarginCycles) * ClkPeriod);
      $display("timeout: tests did not finish");
      abortRun();
   end

endmodule : tbFifoHeadBuffer

`default_nettype wire
